// File: filelist.f
verilog/mips_pkg.sv
verilog/instr_reg.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/mips_control.sv
verilog/mips_datapath.sv
verilog/mips_cpu.sv
verif/tb_clock.sv
verif/mips_checker.sv
verif/mips_assert.sv
verif/mips_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the MIPS testbench with Verilator and run it once
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module mips_tb -f filelist.f -o mips_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/mips_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1

// File: verif/mips_tb.sv
`timescale 1ns/10ps

module mips_tb import mips_pkg::*; ();

    localparam int prog_len    = 60;
    localparam int data_base   = 64;    // First word of the data region
    localparam int data_words  = 64;
    localparam int mem_words   = 1 << mem_idx_w;
    localparam int watchdog_ns = prog_len * 5 * 10 + 2000;

    logic   clk;
    logic   reset = 1'b1;
    word_t  mem_rdata;
    word_t  mem_addr;
    word_t  mem_wdata;
    logic   mem_we;
    logic   mem_ifetch;
    logic   halted;
    logic   timed_out = 1'b0;
    int     error_count;
    int     fetch_count;
    int     store_count;
    integer seed = 32'h1dfb;
    word_t  init_image [mem_words];
    word_t  mem [mem_words];

    tb_clock u_clock (.clk(clk));

    mips_cpu uut (
        .clk        (clk),
        .reset      (reset),
        .mem_rdata  (mem_rdata),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_we     (mem_we),
        .mem_ifetch (mem_ifetch)
    );

    mips_checker u_checker (
        .clk         (clk),
        .reset       (reset),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_we      (mem_we),
        .mem_ifetch  (mem_ifetch),
        .init_image  (init_image),
        .halted      (halted),
        .error_count (error_count),
        .fetch_count (fetch_count),
        .store_count (store_count)
    );

    // --------------------------------------------------
    // Unified memory, loaded from the image during reset
    // --------------------------------------------------
    assign mem_rdata = mem[mem_addr[mem_idx_w+1:2]];

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < mem_words; i++) begin
                mem[i] <= init_image[i];
            end
        end else if (mem_we) begin
            mem[mem_addr[mem_idx_w+1:2]] <= mem_wdata;
        end
    end

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic funct_t pick_funct(int k);
        case (k)
            0:       return fn_add;
            1:       return fn_sub;
            2:       return fn_and;
            3:       return fn_or;
            default: return fn_slt;
        endcase
    endfunction

    function automatic word_t encode_rtype(funct_t fn, reg_addr_t rd, reg_addr_t rs,
                                           reg_addr_t rt);
        return {op_rtype, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t encode_itype(opcode_t op, reg_addr_t rs, reg_addr_t rt, imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic generate_program();
        reg_addr_t rs;
        reg_addr_t rt;
        int        kind;
        int        reach;
        for (int i = 0; i < mem_words; i++) begin
            init_image[i] = {24'hdead00, 8'(i)};    // Unused words carry their own index
        end
        for (int i = data_base; i < data_base + data_words; i++) begin
            init_image[i] = $random(seed);
        end
        for (int i = 0; i < prog_len - 1; i++) begin
            rs    = reg_addr_t'(rand_below(32));
            rt    = reg_addr_t'(rand_below(32));
            kind  = rand_below(12);
            reach = (prog_len - 1 - i < 4) ? prog_len - 1 - i : 4;    // Never past the halt
            case (kind)
                0, 1, 2, 3, 4: init_image[i] = encode_rtype(pick_funct(kind),
                                                            reg_addr_t'(rand_below(32)), rs, rt);
                5, 6: init_image[i] = encode_itype(op_addi, rs, rt, imm_t'($random(seed)));
                7, 8: init_image[i] = encode_itype(op_lw, 5'd0, rt,
                                                   imm_t'(4 * (data_base + rand_below(data_words))));
                9: init_image[i] = encode_itype(op_sw, 5'd0, rt,
                                                imm_t'(4 * (data_base + rand_below(data_words))));
                10: begin
                    if (rand_below(4) == 0) begin
                        rt = rs;    // Equal operands make a taken branch likely
                    end
                    init_image[i] = encode_itype(op_beq, rs, rt, imm_t'(rand_below(reach)));
                end
                default: init_image[i] = {op_j, target_t'(i + 1 + rand_below(reach))};
            endcase
        end
        init_image[prog_len-1] = {op_j, target_t'(prog_len - 1)};
    endtask

    initial begin : watchdog
        #(watchdog_ns);
        $display("Timeout: the program did not reach its halt within %0d ns", watchdog_ns);
        timed_out = 1'b1;
    end

    initial begin : main
        int total;
        generate_program();
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        wait (halted || timed_out);
        total = error_count + (timed_out ? 1 : 0);
        $display("Run finished: %0d fetches, %0d stores checked, %0d errors",
                 fetch_count, store_count, total);
        if (total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: verif/mips_assert.sv
`timescale 1ns/10ps

module mips_assert import mips_pkg::*; (
    input logic       clk,
    input logic       reset,
    input cpu_state_e state,
    input ctrl_t      ctrl
);

    // A store never shares a cycle with an instruction fetch
    no_store_in_fetch: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.mem_we && (state == st_fetch)))
        else $error("mem_we is high in st_fetch");

    fetch_strobe_in_fetch: assert property (@(posedge clk) disable iff (reset)
        ctrl.mem_fetch == (state == st_fetch))
        else $error("mem_ifetch does not match st_fetch");

    reset_to_fetch: assert property (@(posedge clk) reset |=> (state == st_fetch))
        else $error("state is not st_fetch after reset");

endmodule

bind mips_control mips_assert u_assert (
    .clk   (clk),
    .reset (reset),
    .state (state),
    .ctrl  (ctrl)
);

// File: verif/mips_checker.sv
`timescale 1ns/10ps

module mips_checker import mips_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  word_t mem_addr,
    input  word_t mem_wdata,
    input  logic  mem_we,
    input  logic  mem_ifetch,
    input  word_t init_image [1 << mem_idx_w],
    output logic  halted,
    output int    error_count,
    output int    fetch_count,
    output int    store_count
);

    word_t model_mem [1 << mem_idx_w];
    word_t regs [32];
    word_t model_pc;
    word_t last_fetch;
    int    cycle;
    int    last_cycle;
    int    gap;            // Fetch-to-fetch spacing owed by the last instruction
    word_t store_addr [$];
    word_t store_data [$];

    function automatic int cycles_for(opcode_t op);
        case (op)
            op_beq, op_j: return 3;
            op_lw:        return 5;
            default:      return 4;
        endcase
    endfunction

    task automatic write_reg(reg_addr_t idx, word_t value);
        if (idx != '0) begin
            regs[idx] = value;    // Register zero never changes
        end
    endtask

    task automatic reset_model();
        for (int i = 0; i < (1 << mem_idx_w); i++) begin
            model_mem[i] = init_image[i];
        end
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        model_pc    = '0;
        last_fetch  = '0;
        cycle       = 0;
        last_cycle  = 0;
        gap         = 0;
        halted      = 1'b0;
        error_count = 0;
        fetch_count = 0;
        store_count = 0;
        store_addr.delete();
        store_data.delete();
    endtask

    // --------------------------------------------------
    // Architectural step of one instruction
    // --------------------------------------------------
    task automatic step_model();
        word_t ins;
        word_t a;
        word_t b;
        word_t sext;
        word_t sum;
        word_t next_pc;
        ins     = model_mem[model_pc[mem_idx_w+1:2]];
        a       = regs[ins[25:21]];
        b       = regs[ins[20:16]];
        sext    = {{16{ins[15]}}, ins[15:0]};
        sum     = a + sext;
        next_pc = model_pc + 32'd4;
        gap     = cycles_for(ins[31:26]);
        case (ins[31:26])
            op_rtype: begin
                case (ins[5:0])
                    fn_add:  write_reg(ins[15:11], a + b);
                    fn_sub:  write_reg(ins[15:11], a - b);
                    fn_and:  write_reg(ins[15:11], a & b);
                    fn_or:   write_reg(ins[15:11], a | b);
                    fn_slt:  write_reg(ins[15:11], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                    default: ;
                endcase
            end
            op_addi: write_reg(ins[20:16], sum);
            op_lw:   write_reg(ins[20:16], model_mem[sum[mem_idx_w+1:2]]);
            op_sw: begin
                model_mem[sum[mem_idx_w+1:2]] = b;
                store_addr.push_back(sum);
                store_data.push_back(b);
            end
            op_beq: begin
                if (a == b) begin
                    next_pc = next_pc + (sext << 2);    // Offset counts from the next PC
                end
            end
            op_j:    next_pc = {next_pc[31:28], ins[25:0], 2'b00};
            default: ;
        endcase
        model_pc = next_pc;
    endtask

    task automatic check_fetch();
        if ((fetch_count > 0) && (cycle - last_cycle != gap)) begin
            $display("FAILED at %0t: mem_ifetch spacing expected %0d, got %0d",
                     $time, gap, cycle - last_cycle);
            error_count++;
        end
        if (mem_addr !== model_pc) begin
            $display("FAILED at %0t: mem_addr expected %h, got %h", $time, model_pc, mem_addr);
            error_count++;
        end
        if ((fetch_count > 0) && (mem_addr == last_fetch)) begin
            halted = 1'b1;    // The closing jump to itself
            if (store_addr.size() != 0) begin
                $display("%0d expected stores never reached memory", store_addr.size());
                error_count++;
            end
        end else begin
            step_model();
        end
        fetch_count++;
        last_fetch = mem_addr;
        last_cycle = cycle;
    endtask

    task automatic check_store();
        word_t exp_addr;
        word_t exp_data;
        if (store_addr.size() == 0) begin
            $display("Memory write at %0t to %h while no store was expected", $time, mem_addr);
            error_count++;
        end else begin
            exp_addr = store_addr.pop_front();
            exp_data = store_data.pop_front();
            if (mem_addr !== exp_addr) begin
                $display("FAILED at %0t: mem_addr expected %h, got %h",
                         $time, exp_addr, mem_addr);
                error_count++;
            end
            if (mem_wdata !== exp_data) begin
                $display("FAILED at %0t: mem_wdata expected %h, got %h",
                         $time, exp_data, mem_wdata);
                error_count++;
            end
            store_count++;
        end
    endtask

    // Outputs have settled by the falling edge
    always @(negedge clk) begin
        if (reset) begin
            reset_model();
        end else if (!halted) begin
            cycle++;
            if (mem_ifetch) begin
                check_fetch();
            end
            if (mem_we) begin
                check_store();
            end
        end
    end

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;    // 10 ns period
    end

endmodule

// File: verilog/mips_cpu.sv
`timescale 1ns/10ps

module mips_cpu import mips_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  word_t mem_rdata,
    output word_t mem_addr,
    output word_t mem_wdata,
    output logic  mem_we,
    output logic  mem_ifetch
);

    ctrl_t         ctrl;
    instr_fields_t fields;

    mips_control u_control (
        .clk    (clk),
        .reset  (reset),
        .fields (fields),
        .ctrl   (ctrl)
    );

    mips_datapath u_datapath (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .mem_rdata (mem_rdata),
        .fields    (fields),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

    // Memory strobes come straight from the control word
    assign mem_we     = ctrl.mem_we;
    assign mem_ifetch = ctrl.mem_fetch;

endmodule

// File: verilog/mips_datapath.sv
`timescale 1ns/10ps

module mips_datapath import mips_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  ctrl_t         ctrl,
    input  word_t         mem_rdata,
    output instr_fields_t fields,
    output word_t         mem_addr,
    output word_t         mem_wdata
);

    word_t     pc;
    word_t     pc_next;
    logic      pc_en;
    word_t     reg_a;
    word_t     reg_b;
    word_t     alu_out;    // Result register
    word_t     mdr;        // Memory data register
    word_t     rf_a;
    word_t     rf_b;
    word_t     alu_a;
    word_t     alu_b;
    word_t     alu_result;
    logic      alu_zero;
    word_t     imm_ext;
    reg_addr_t wr_addr;
    word_t     wr_data;

    instr_reg u_instr_reg (
        .clk       (clk),
        .reset     (reset),
        .load      (ctrl.ir_load),
        .mem_rdata (mem_rdata),
        .fields    (fields)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .reset     (reset),
        .rd_addr_a (fields.rs),
        .rd_addr_b (fields.rt),
        .wr_en     (ctrl.rf_write),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_data_a (rf_a),
        .rd_data_b (rf_b)
    );

    alu u_alu (
        .op     (ctrl.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // --------------------------------------------------
    // Operand and write-back multiplexers
    // --------------------------------------------------
    assign imm_ext = {{(word_w-imm_w){fields.imm[imm_w-1]}}, fields.imm};
    assign alu_a   = ctrl.alu_a_sel ? reg_a : pc;

    always_comb begin
        case (ctrl.alu_b_sel)
            alu_b_reg:  alu_b = reg_b;
            alu_b_four: alu_b = 32'd4;
            alu_b_imm:  alu_b = imm_ext;
            default:    alu_b = imm_ext << 2;
        endcase
    end

    assign wr_addr = ctrl.rf_dst_sel ? fields.rt : fields.rd;
    assign wr_data = ctrl.rf_src_sel ? mdr : alu_out;

    // PC plus four is already in pc when a branch or jump resolves
    always_comb begin
        case (ctrl.pc_src)
            pc_src_branch: pc_next = alu_out;
            pc_src_jump:   pc_next = {pc[31:28], fields.target, 2'b00};
            default:       pc_next = alu_result;
        endcase
    end

    assign pc_en = ctrl.pc_load || (ctrl.branch && alu_zero);    // Taken beq

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (pc_en) begin
            pc <= pc_next;
        end
    end

    // Operand and result registers follow their sources every cycle
    always_ff @(posedge clk) begin
        reg_a   <= rf_a;
        reg_b   <= rf_b;
        alu_out <= alu_result;
        mdr     <= mem_rdata;
    end

    assign mem_addr  = ctrl.addr_sel ? alu_out : pc;
    assign mem_wdata = reg_b;

endmodule

// File: verilog/mips_control.sv
`timescale 1ns/10ps

module mips_control import mips_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  instr_fields_t fields,
    output ctrl_t         ctrl
);

    cpu_state_e state;
    cpu_state_e next_state;
    logic       op_known;

    assign op_known = (fields.op == op_rtype) || (fields.op == op_addi) ||
                      (fields.op == op_lw)    || (fields.op == op_sw)   ||
                      (fields.op == op_beq)   || (fields.op == op_j);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_fetch;
        end else begin
            state <= next_state;
        end
    end

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------
    always_comb begin
        next_state = st_fetch;
        case (state)
            st_fetch:  next_state = st_decode;
            st_decode: next_state = op_known ? st_exec : st_fetch;    // Unknown op is a no-op
            st_exec: begin
                if ((fields.op == op_lw) || (fields.op == op_sw)) begin
                    next_state = st_mem;
                end else if ((fields.op == op_rtype) || (fields.op == op_addi)) begin
                    next_state = st_wb;
                end
            end
            st_mem:  next_state = (fields.op == op_lw) ? st_wb : st_fetch;
            default: next_state = st_fetch;
        endcase
    end

    // --------------------------------------------------
    // Control outputs per state
    // --------------------------------------------------
    always_comb begin
        ctrl = '0;
        ctrl.alu_b_sel = alu_b_four;
        ctrl.alu_op    = alu_add;
        case (state)
            st_fetch: begin
                ctrl.mem_fetch = 1'b1;
                ctrl.ir_load   = 1'b1;
                ctrl.pc_load   = 1'b1;    // PC plus four from the ALU
                ctrl.pc_src    = pc_src_inc;
            end
            st_decode: begin
                ctrl.alu_b_sel = alu_b_imm_sh;    // Branch target into the result register
            end
            st_exec: begin
                ctrl.alu_a_sel = 1'b1;
                case (fields.op)
                    op_rtype: begin
                        ctrl.alu_b_sel = alu_b_reg;
                        case (fields.funct)
                            fn_sub:  ctrl.alu_op = alu_sub;
                            fn_and:  ctrl.alu_op = alu_and;
                            fn_or:   ctrl.alu_op = alu_or;
                            fn_slt:  ctrl.alu_op = alu_slt;
                            default: ctrl.alu_op = alu_add;
                        endcase
                    end
                    op_beq: begin
                        ctrl.alu_b_sel = alu_b_reg;
                        ctrl.alu_op    = alu_sub;
                        ctrl.branch    = 1'b1;
                        ctrl.pc_src    = pc_src_branch;
                    end
                    op_j: begin
                        ctrl.pc_load = 1'b1;
                        ctrl.pc_src  = pc_src_jump;
                    end
                    default: ctrl.alu_b_sel = alu_b_imm;    // addi, lw and sw address
                endcase
            end
            st_mem: begin
                ctrl.addr_sel = 1'b1;
                ctrl.mem_we   = (fields.op == op_sw);
            end
            st_wb: begin
                ctrl.rf_write   = 1'b1;
                ctrl.rf_dst_sel = (fields.op != op_rtype);
                ctrl.rf_src_sel = (fields.op == op_lw);
            end
            default: ;
        endcase
    end

endmodule

// File: verilog/alu.sv
`timescale 1ns/10ps

module alu import mips_pkg::*; (
    input  alu_op_e op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result,
    output logic    zero
);

    logic less;    // Signed comparison for slt

    assign less = ($signed(a) < $signed(b));

    always_comb begin
        case (op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_slt: result = {{(word_w-1){1'b0}}, less};
            default: result = a + b;
        endcase
    end

    // A beq subtracts its operands, so zero means they are equal
    assign zero = (result == '0);

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/10ps

module reg_file import mips_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rd_addr_a,
    input  reg_addr_t rd_addr_b,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data,
    output word_t     rd_data_a,
    output word_t     rd_data_b
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin    // Register zero stays zero
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
    assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

endmodule

// File: verilog/instr_reg.sv
`timescale 1ns/10ps

module instr_reg import mips_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          load,
    input  word_t         mem_rdata,
    output instr_fields_t fields
);

    word_t instr;    // Word held from the last fetch

    always_ff @(posedge clk) begin
        if (reset) begin
            instr <= '0;
        end else if (load) begin
            instr <= mem_rdata;
        end
    end

    // --------------------------------------------------
    // Field split, taken from the stored word only
    // --------------------------------------------------
    always_comb begin
        fields.op     = instr[31:26];
        fields.rs     = instr[25:21];
        fields.rt     = instr[20:16];
        fields.rd     = instr[15:11];
        fields.shamt  = instr[10:6];
        fields.funct  = instr[5:0];
        fields.imm    = instr[15:0];    // Overlaps rd, shamt and funct
        fields.target = instr[25:0];
    end

endmodule

// File: verilog/mips_pkg.sv
package mips_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int word_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int opcode_w   = 6;
    localparam int funct_w    = 6;
    localparam int imm_w      = 16;
    localparam int target_w   = 26;
    localparam int mem_idx_w  = 8;    // Word index into the unified memory

    typedef logic [word_w-1:0]     word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [opcode_w-1:0]   opcode_t;
    typedef logic [funct_w-1:0]    funct_t;
    typedef logic [imm_w-1:0]      imm_t;
    typedef logic [target_w-1:0]   target_t;

    // --------------------------------------------------
    // Instruction encodings
    // --------------------------------------------------
    localparam opcode_t op_rtype = 6'h00;
    localparam opcode_t op_j     = 6'h02;
    localparam opcode_t op_beq   = 6'h04;
    localparam opcode_t op_addi  = 6'h08;
    localparam opcode_t op_lw    = 6'h23;
    localparam opcode_t op_sw    = 6'h2b;

    localparam funct_t fn_add = 6'h20;
    localparam funct_t fn_sub = 6'h22;
    localparam funct_t fn_and = 6'h24;
    localparam funct_t fn_or  = 6'h25;
    localparam funct_t fn_slt = 6'h2a;

    // Multiplexer selects of more than one bit
    localparam logic [1:0] pc_src_inc    = 2'd0;
    localparam logic [1:0] pc_src_branch = 2'd1;
    localparam logic [1:0] pc_src_jump   = 2'd2;

    localparam logic [1:0] alu_b_reg    = 2'd0;
    localparam logic [1:0] alu_b_four   = 2'd1;
    localparam logic [1:0] alu_b_imm    = 2'd2;
    localparam logic [1:0] alu_b_imm_sh = 2'd3;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_slt
    } alu_op_e;

    typedef enum logic [2:0] {
        st_fetch, st_decode, st_exec, st_mem, st_wb
    } cpu_state_e;

    typedef struct packed {
        opcode_t   op;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        reg_addr_t shamt;
        funct_t    funct;
        imm_t      imm;
        target_t   target;
    } instr_fields_t;

    typedef struct packed {
        logic       ir_load;
        logic       pc_load;
        logic [1:0] pc_src;
        logic       addr_sel;     // 0 PC, 1 result register
        logic       alu_a_sel;    // 0 PC, 1 register A
        logic [1:0] alu_b_sel;
        alu_op_e    alu_op;
        logic       branch;
        logic       rf_write;
        logic       rf_dst_sel;   // 0 rd, 1 rt
        logic       rf_src_sel;   // 0 result register, 1 memory data register
        logic       mem_we;
        logic       mem_fetch;
    } ctrl_t;

endpackage
